/* sram_cfg.svh */
//----------------------------------------------------------
// AXI SRAM configuration
//----------------------------------------------------------
`ifndef SRAM_CFG_SVH
`define SRAM_CFG_SVH

// byte address width
`define SRAM_ADDR_W 32

`define SRAM_DATA_W 64
`define SRAM_STRB_W 8

// 512 words of 64 bits for bytes 0 to 4095
`define SRAM_DEPTH 512
`define SRAM_IDX_W 9

`endif

/* axi_sram_pkg.sv */
//----------------------------------------------------------
// AXI SRAM types
//----------------------------------------------------------
package axi_sram_pkg;

   // AXI burst encoding
   typedef enum logic [1:0] {
      BURST_FIXED = 2'b00,
      BURST_INCR  = 2'b01,
      BURST_WRAP  = 2'b10
   } burst_e;

   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_SLVERR = 2'b10
   } resp_e;

   typedef enum logic [1:0] {
      RD_IDLE,
      RD_FETCH, // array read of beat 0
      RD_DATA
   } rd_state_e;

   typedef enum logic [1:0] {
      WR_IDLE,
      WR_DATA,
      WR_RESP
   } wr_state_e;

endpackage

/* burst_addr_gen.sv */
//----------------------------------------------------------
// AXI burst address generator
//----------------------------------------------------------
`include "sram_cfg.svh"

module burst_addr_gen
   import axi_sram_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    load,
   input  logic                    step,
   input  logic [`SRAM_ADDR_W-1:0] base_addr,
   input  logic [7:0]              len,
   input  burst_e                  burst,
   output logic [`SRAM_IDX_W-1:0]  word_idx,
   output logic                    in_range
);
   localparam int OFS_W  = $clog2(`SRAM_STRB_W);
   localparam int WORD_W = `SRAM_ADDR_W - OFS_W;

   logic [WORD_W-1:0] cur_word;
   logic [WORD_W-1:0] next_word;
   logic [WORD_W-1:0] wrap_mask;
   logic [7:0]        len_q;
   burst_e            burst_q;

   assign wrap_mask = WORD_W'(len_q); // len + 1 is a power of two for WRAP

   always_comb begin
      case (burst_q)
         BURST_FIXED: next_word = cur_word;
         BURST_WRAP:  next_word = (cur_word & ~wrap_mask) | ((cur_word + 1'b1) & wrap_mask);
         default:     next_word = cur_word + 1'b1;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         cur_word <= '0;
         len_q    <= '0;
         burst_q  <= BURST_INCR;
      end else if (load) begin
         cur_word <= base_addr[`SRAM_ADDR_W-1:OFS_W]; // byte offset dropped
         len_q    <= len;
         burst_q  <= burst;
      end else if (step) begin
         cur_word <= next_word;
      end
   end

   assign word_idx = cur_word[`SRAM_IDX_W-1:0];
   assign in_range = (cur_word < WORD_W'(`SRAM_DEPTH));

   a_wrap_len: assert property (@(posedge clk) disable iff (rst)
      (load && burst == BURST_WRAP) |-> (len inside {8'd1, 8'd3, 8'd7, 8'd15}))
      else $error("WRAP burst loaded with a length other than 2, 4, 8 or 16 beats");

endmodule

/* sram_array.sv */
//----------------------------------------------------------
// Byte-strobed dual-port word memory
//----------------------------------------------------------
`include "sram_cfg.svh"

module sram_array (
   input  logic                    clk,
   // read port
   input  logic                    re,
   input  logic [`SRAM_IDX_W-1:0]  raddr,
   output logic [`SRAM_DATA_W-1:0] rdata,
   // write port
   input  logic                    we,
   input  logic [`SRAM_IDX_W-1:0]  waddr,
   input  logic [`SRAM_DATA_W-1:0] wdata,
   input  logic [`SRAM_STRB_W-1:0] wstrb
);
   localparam int BYTE_W = `SRAM_DATA_W / `SRAM_STRB_W;

   logic [`SRAM_DATA_W-1:0] mem [`SRAM_DEPTH];

   // only strobed bytes change
   always_ff @(posedge clk) begin
      if (we) begin
         for (int b = 0; b < `SRAM_STRB_W; b++) begin
            if (wstrb[b]) begin
               mem[waddr][b*BYTE_W +: BYTE_W] <= wdata[b*BYTE_W +: BYTE_W];
            end
         end
      end
   end

   // holds last word while re is low
   always_ff @(posedge clk) begin
      if (re) begin
         rdata <= mem[raddr]; // old data on a same-cycle write
      end
   end

endmodule

/* axi_sram_ctrl.sv */
//----------------------------------------------------------
// AXI SRAM channel control
//----------------------------------------------------------
`include "sram_cfg.svh"

module axi_sram_ctrl
   import axi_sram_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst,
   // AR / R
   input  logic [`SRAM_ADDR_W-1:0] araddr,
   input  logic [7:0]              arlen,
   input  burst_e                  arburst,
   input  logic                    arvalid,
   output logic                    arready,
   output logic [`SRAM_DATA_W-1:0] rdata,
   output resp_e                   rresp,
   output logic                    rlast,
   output logic                    rvalid,
   input  logic                    rready,
   // AW / W / B
   input  logic [`SRAM_ADDR_W-1:0] awaddr,
   input  logic [7:0]              awlen,
   input  burst_e                  awburst,
   input  logic                    awvalid,
   output logic                    awready,
   input  logic                    wlast,
   input  logic                    wvalid,
   output logic                    wready,
   output resp_e                   bresp,
   output logic                    bvalid,
   input  logic                    bready,
   // read address generator
   output logic                    rd_load,
   output logic                    rd_step,
   output logic [`SRAM_ADDR_W-1:0] rd_base_addr,
   output logic [7:0]              rd_len,
   output burst_e                  rd_burst,
   input  logic                    rd_in_range,
   // write address generator
   output logic                    wr_load,
   output logic                    wr_step,
   output logic [`SRAM_ADDR_W-1:0] wr_base_addr,
   output logic [7:0]              wr_len,
   output burst_e                  wr_burst,
   input  logic                    wr_in_range,
   // array
   output logic                    mem_re,
   output logic                    mem_we,
   input  logic [`SRAM_DATA_W-1:0] mem_rdata
);
   rd_state_e  rd_state;
   wr_state_e  wr_state;
   logic [7:0] rd_len_q;
   logic [7:0] rd_cnt;
   logic       rd_range_q; // range flag of the word now in the array register
   logic [7:0] wr_len_q;
   logic [7:0] wr_cnt;
   logic       wr_err;     // sticky over the burst
   logic       ar_hs;
   logic       r_hs;
   logic       aw_hs;
   logic       w_hs;
   logic       b_hs;

   // read channel
   assign arready = (rd_state == RD_IDLE);
   assign ar_hs   = arvalid && arready;
   assign rvalid  = (rd_state == RD_DATA);
   assign r_hs    = rvalid && rready;
   assign rlast   = rvalid && (rd_cnt == rd_len_q);
   assign rresp   = rd_range_q ? RESP_OKAY : RESP_SLVERR;
   assign rdata   = rd_range_q ? mem_rdata : '0;

   assign rd_base_addr = araddr;
   assign rd_len       = arlen;
   assign rd_burst     = arburst;
   assign rd_load      = ar_hs;

   // generator runs one beat ahead of the R channel
   assign mem_re  = (rd_state == RD_FETCH) || (r_hs && !rlast);
   assign rd_step = mem_re;

   always_ff @(posedge clk) begin
      if (rst) begin
         rd_state <= RD_IDLE;
      end else begin
         case (rd_state)
            RD_IDLE:  if (ar_hs) rd_state <= RD_FETCH;
            RD_FETCH: rd_state <= RD_DATA;
            RD_DATA:  if (r_hs && rlast) rd_state <= RD_IDLE;
            default:  rd_state <= RD_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (ar_hs) begin
         rd_len_q <= arlen;
         rd_cnt   <= '0;
      end else if (r_hs) begin
         rd_cnt <= rd_cnt + 8'd1;
      end
      if (mem_re) begin
         rd_range_q <= rd_in_range;
      end
   end

   // write channel
   assign awready = (wr_state == WR_IDLE);
   assign aw_hs   = awvalid && awready;
   assign wready  = (wr_state == WR_DATA);
   assign w_hs    = wvalid && wready;
   assign bvalid  = (wr_state == WR_RESP);
   assign b_hs    = bvalid && bready;
   assign bresp   = wr_err ? RESP_SLVERR : RESP_OKAY;

   assign wr_base_addr = awaddr;
   assign wr_len       = awlen;
   assign wr_burst     = awburst;
   assign wr_load      = aw_hs;
   assign wr_step      = w_hs;
   assign mem_we       = w_hs && wr_in_range; // out of range beats dropped

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_state <= WR_IDLE;
         wr_err   <= 1'b0;
      end else begin
         case (wr_state)
            WR_IDLE: begin
               if (aw_hs) begin
                  wr_state <= WR_DATA;
                  wr_err   <= 1'b0;
               end
            end
            WR_DATA: begin
               if (w_hs && !wr_in_range) wr_err <= 1'b1;
               if (w_hs && wlast) wr_state <= WR_RESP;
            end
            WR_RESP: if (b_hs) wr_state <= WR_IDLE;
            default: wr_state <= WR_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (aw_hs) begin
         wr_len_q <= awlen;
         wr_cnt   <= '0;
      end else if (w_hs) begin
         wr_cnt <= wr_cnt + 8'd1;
      end
   end

   a_wlast_len: assert property (@(posedge clk) disable iff (rst)
      w_hs |-> (wlast == (wr_cnt == wr_len_q)))
      else $error("wlast does not match the stored burst length");

   a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
      (rvalid && !rready) |=>
         (rvalid && $stable(rdata) && $stable(rresp) && $stable(rlast)))
      else $error("R beat dropped or changed before it was taken");

endmodule

/* axi_sram_top.sv */
//----------------------------------------------------------
// AXI4 SRAM slave
//----------------------------------------------------------
`include "sram_cfg.svh"

module axi_sram_top
   import axi_sram_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst,
   input  logic [`SRAM_ADDR_W-1:0] araddr,
   input  logic [7:0]              arlen,
   input  burst_e                  arburst,
   input  logic                    arvalid,
   output logic                    arready,
   output logic [`SRAM_DATA_W-1:0] rdata,
   output resp_e                   rresp,
   output logic                    rlast,
   output logic                    rvalid,
   input  logic                    rready,
   input  logic [`SRAM_ADDR_W-1:0] awaddr,
   input  logic [7:0]              awlen,
   input  burst_e                  awburst,
   input  logic                    awvalid,
   output logic                    awready,
   input  logic [`SRAM_DATA_W-1:0] wdata,
   input  logic [`SRAM_STRB_W-1:0] wstrb,
   input  logic                    wlast,
   input  logic                    wvalid,
   output logic                    wready,
   output resp_e                   bresp,
   output logic                    bvalid,
   input  logic                    bready
);
   logic                    rd_load;
   logic                    rd_step;
   logic [`SRAM_ADDR_W-1:0] rd_base_addr;
   logic [7:0]              rd_len;
   burst_e                  rd_burst;
   logic                    rd_in_range;
   logic [`SRAM_IDX_W-1:0]  rd_idx;
   logic                    wr_load;
   logic                    wr_step;
   logic [`SRAM_ADDR_W-1:0] wr_base_addr;
   logic [7:0]              wr_len;
   burst_e                  wr_burst;
   logic                    wr_in_range;
   logic [`SRAM_IDX_W-1:0]  wr_idx;
   logic                    mem_re;
   logic                    mem_we;
   logic [`SRAM_DATA_W-1:0] mem_rdata;

   // port names match the wires above
   axi_sram_ctrl axi_sram_ctrl_inst (.*);

   burst_addr_gen rd_addr_gen (
      .clk       (clk),
      .rst       (rst),
      .load      (rd_load),
      .step      (rd_step),
      .base_addr (rd_base_addr),
      .len       (rd_len),
      .burst     (rd_burst),
      .word_idx  (rd_idx),
      .in_range  (rd_in_range)
   );

   burst_addr_gen wr_addr_gen (
      .clk       (clk),
      .rst       (rst),
      .load      (wr_load),
      .step      (wr_step),
      .base_addr (wr_base_addr),
      .len       (wr_len),
      .burst     (wr_burst),
      .word_idx  (wr_idx),
      .in_range  (wr_in_range)
   );

   sram_array sram_array_inst (
      .clk   (clk),
      .re    (mem_re),
      .raddr (rd_idx),
      .rdata (mem_rdata),
      .we    (mem_we),
      .waddr (wr_idx),
      .wdata (wdata), // W payload goes straight in
      .wstrb (wstrb)
   );

endmodule

/* tb_axi_sram.sv */
//----------------------------------------------------------
// AXI SRAM slave testbench
//----------------------------------------------------------
`include "sram_cfg.svh"

module tb_axi_sram
   import axi_sram_pkg::*;
;
   localparam int MEM_BYTES = `SRAM_DEPTH * `SRAM_STRB_W;
   localparam int SEL_AW = 0;
   localparam int SEL_W  = 1;
   localparam int SEL_B  = 2;
   localparam int SEL_AR = 3;
   localparam int SEL_R  = 4;

   logic                    clk = 1'b0;
   logic                    rst;
   logic [`SRAM_ADDR_W-1:0] araddr;
   logic [7:0]              arlen;
   burst_e                  arburst;
   logic                    arvalid;
   logic                    arready;
   logic [`SRAM_DATA_W-1:0] rdata;
   resp_e                   rresp;
   logic                    rlast;
   logic                    rvalid;
   logic                    rready;
   logic [`SRAM_ADDR_W-1:0] awaddr;
   logic [7:0]              awlen;
   burst_e                  awburst;
   logic                    awvalid;
   logic                    awready;
   logic [`SRAM_DATA_W-1:0] wdata;
   logic [`SRAM_STRB_W-1:0] wstrb;
   logic                    wlast;
   logic                    wvalid;
   logic                    wready;
   resp_e                   bresp;
   logic                    bvalid;
   logic                    bready;

   logic [7:0]              ref_mem [MEM_BYTES]; // byte image of the array
   logic [15:0]             lfsr = 16'd85;
   logic [`SRAM_DATA_W-1:0] got_rdata;
   resp_e                   got_rresp;
   logic                    got_rlast;
   resp_e                   got_bresp;
   bit                      r_throttle = 1'b0;
   bit                      w_gaps = 1'b0;
   int                      n_pass = 0;
   int                      n_fail = 0;

   axi_sram_top axi_sram_top_inst (.*);

   always #50 clk = ~clk;

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic lfsr_bit();
      logic fb;
      fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      return fb;
   endfunction

   function automatic logic [63:0] lfsr_bits(input int n);
      logic [63:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[62:0], lfsr_bit()};
      end
      return v;
   endfunction

   // AXI address of the next beat
   function automatic logic [31:0] next_addr(input logic [31:0] a, input int len,
                                             input burst_e burst);
      logic [31:0] span;
      logic [31:0] lo;
      span = 32'((len + 1) * `SRAM_STRB_W);
      lo   = (a / span) * span; // wrap boundary
      case (burst)
         BURST_FIXED: return a;
         BURST_WRAP:  return (a + 8 >= lo + span) ? lo : a + 8;
         default:     return a + 8;
      endcase
   endfunction

   function automatic logic [63:0] expected_word(input logic [31:0] a);
      logic [63:0] w;
      w = '0;
      if (a < MEM_BYTES) begin
         for (int b = 0; b < 8; b++) begin
            w[b*8 +: 8] = ref_mem[{a[11:3], 3'(b)}];
         end
      end
      return w;
   endfunction

   function automatic logic flag_of(input int sel);
      case (sel)
         SEL_AW:  return awready;
         SEL_W:   return wvalid && wready;
         SEL_B:   return bvalid;
         SEL_AR:  return arready;
         default: return rvalid && rready;
      endcase
   endfunction

   task automatic model_write(input logic [31:0] a, input logic [63:0] d, input logic [7:0] s);
      if (a < MEM_BYTES) begin
         for (int b = 0; b < 8; b++) begin
            if (s[b]) ref_mem[{a[11:3], 3'(b)}] = d[b*8 +: 8];
         end
      end
   endtask

   task automatic check(input bit ok, input string msg);
      assert (ok) begin
         n_pass = n_pass + 1;
      end else begin
         n_fail = n_fail + 1;
         $display("Error at time %0t: %s", $time, msg);
      end
   endtask

   // samples at negedge and returns on the handshake edge
   task automatic wait_flag(input int sel, input string what);
      int cnt;
      cnt = 0;
      @(negedge clk);
      while (!flag_of(sel) && cnt < 200) begin
         @(posedge clk);
         #10;
         if (sel == SEL_R && r_throttle) rready = lfsr_bit();
         if (sel == SEL_W && w_gaps && !wvalid) wvalid = lfsr_bit();
         cnt++;
         @(negedge clk);
      end
      if (flag_of(sel)) begin
         if (sel == SEL_R) begin
            got_rdata = rdata;
            got_rresp = rresp;
            got_rlast = rlast;
         end
         if (sel == SEL_B) got_bresp = bresp;
         @(posedge clk);
      end else begin
         $display("Timeout: no %s within 200 cycles at time %0t", what, $time);
         $display("Verification failed");
         $finish;
      end
   endtask

   task automatic axi_write(input logic [31:0] addr, input int len, input burst_e burst,
                            input bit full_strb);
      logic [31:0] a;
      logic [63:0] d;
      logic [7:0]  s;
      resp_e       exp_resp;
      a        = addr;
      exp_resp = RESP_OKAY;
      awaddr   = addr;
      awlen    = 8'(len);
      awburst  = burst;
      awvalid  = 1'b1;
      wait_flag(SEL_AW, "AW handshake");
      #10;
      awvalid = 1'b0;
      for (int i = 0; i <= len; i++) begin
         d      = lfsr_bits(64);
         s      = full_strb ? 8'hff : 8'(lfsr_bits(8));
         wdata  = d;
         wstrb  = s;
         wlast  = (i == len);
         wvalid = w_gaps ? lfsr_bit() : 1'b1;
         wait_flag(SEL_W, "W beat accepted");
         #10;
         model_write(a, d, s);
         if (a >= MEM_BYTES) exp_resp = RESP_SLVERR;
         a = next_addr(a, len, burst);
      end
      wvalid = 1'b0;
      wlast  = 1'b0;
      bready = 1'b1;
      wait_flag(SEL_B, "B response");
      #10;
      bready = 1'b0;
      check(got_bresp === exp_resp, $sformatf("write at 0x%0h got bresp %0d, expected %0d",
            addr, got_bresp, exp_resp));
      check(!bvalid, $sformatf("write at 0x%0h left bvalid high after the B handshake",
            addr));
   endtask

   task automatic axi_read(input logic [31:0] addr, input int len, input burst_e burst);
      logic [31:0] a;
      logic [63:0] exp;
      resp_e       exp_resp;
      a       = addr;
      araddr  = addr;
      arlen   = 8'(len);
      arburst = burst;
      arvalid = 1'b1;
      wait_flag(SEL_AR, "AR handshake");
      #10;
      arvalid = 1'b0;
      for (int i = 0; i <= len; i++) begin
         rready = r_throttle ? lfsr_bit() : 1'b1;
         wait_flag(SEL_R, "R beat");
         #10;
         exp      = expected_word(a);
         exp_resp = (a < MEM_BYTES) ? RESP_OKAY : RESP_SLVERR;
         check(got_rdata === exp && got_rresp === exp_resp && got_rlast === (i == len),
               $sformatf("read beat %0d at 0x%0h got %h/%0d/%b, expected %h/%0d/%b", i, a,
               got_rdata, got_rresp, got_rlast, exp, exp_resp, i == len));
         a = next_addr(a, len, burst);
      end
      rready = 1'b0;
   endtask

   task automatic test_reset_single();
      @(negedge clk);
      check(arready && awready && !rvalid && !wready && !bvalid,
            "handshake levels after reset");
      @(posedge clk);
      #10;
      axi_write(32'h100, 0, BURST_INCR, 1'b1);
      axi_read(32'h100, 0, BURST_INCR);
   endtask

   task automatic test_incr_strobes();
      axi_write(32'h200, 7, BURST_INCR, 1'b1); // known contents first
      axi_write(32'h200, 7, BURST_INCR, 1'b0);
      axi_read(32'h200, 7, BURST_INCR);
   endtask

   task automatic test_wrap_fixed();
      axi_write(32'h310, 3, BURST_WRAP, 1'b1); // third word of block 0x300
      axi_read(32'h310, 3, BURST_WRAP);
      axi_write(32'h380, 0, BURST_INCR, 1'b1);
      axi_write(32'h380, 2, BURST_FIXED, 1'b0);
      axi_read(32'h380, 0, BURST_INCR);
   endtask

   task automatic test_backpressure();
      r_throttle = 1'b1;
      axi_read(32'h200, 7, BURST_INCR);
      r_throttle = 1'b0;
      w_gaps     = 1'b1;
      axi_write(32'h400, 5, BURST_INCR, 1'b1);
      w_gaps     = 1'b0;
      axi_read(32'h400, 5, BURST_INCR);
   endtask

   task automatic test_out_of_range();
      axi_write(32'd4088, 1, BURST_INCR, 1'b1); // second beat past the end
      axi_read(32'd4088, 1, BURST_INCR);
   endtask

   task automatic test_concurrent();
      fork
         axi_write(32'h500, 3, BURST_INCR, 1'b1);
         axi_read(32'h200, 7, BURST_INCR);
      join
      axi_read(32'h500, 3, BURST_INCR);
   endtask

   task automatic report_test(input string name, input int fails_before);
      $display("%s: %s", name, (n_fail == fails_before) ? "ok" : "FAILED");
   endtask

   initial begin
      int mark;
      rst     = 1'b1;
      araddr  = '0;
      arlen   = '0;
      arburst = BURST_INCR;
      arvalid = 1'b0;
      rready  = 1'b0;
      awaddr  = '0;
      awlen   = '0;
      awburst = BURST_INCR;
      awvalid = 1'b0;
      wdata   = '0;
      wstrb   = '0;
      wlast   = 1'b0;
      wvalid  = 1'b0;
      bready  = 1'b0;
      repeat (2) @(posedge clk);
      #10;
      rst = 1'b0;
      mark = n_fail;
      test_reset_single();
      report_test("reset and single beat", mark);
      mark = n_fail;
      test_incr_strobes();
      report_test("incr burst with strobes", mark);
      mark = n_fail;
      test_wrap_fixed();
      report_test("wrap and fixed bursts", mark);
      mark = n_fail;
      test_backpressure();
      report_test("back-pressure", mark);
      mark = n_fail;
      test_out_of_range();
      report_test("out of range", mark);
      mark = n_fail;
      test_concurrent();
      report_test("concurrent read and write", mark);
      $display("checks passed %0d, failed %0d", n_pass, n_fail);
      if (n_fail == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

/* sim.f */
+incdir+.
axi_sram_pkg.sv
burst_addr_gen.sv
sram_array.sv
axi_sram_ctrl.sv
axi_sram_top.sv
tb_axi_sram.sv

/* run.sh */
#!/bin/sh
# build and run the AXI SRAM testbench with Verilator
verilator --binary --timing --assert -Wno-fatal --top-module tb_axi_sram \
   -f sim.f -o tb_axi_sram || exit 1
out=$(./obj_dir/tb_axi_sram)
echo "$out"
echo "$out" | grep -q "Verification passed" && exit 0 || exit 1
